// ==== logic/jtag_user_config.svh ====
`ifndef JTAG_USER_CONFIG_SVH
`define JTAG_USER_CONFIG_SVH

// Bits carried by one inbound DR scan
`define JTAG_BYTE_WIDTH 8

// Width of row and col in each tile
`define JTAG_GRID_BITS 18

// Running sum wraps at this width
`define JTAG_RESULT_WIDTH 16

`endif

// ==== logic/jtag_user_pkg.sv ====
`include "jtag_user_config.svh"

package jtag_user_pkg;

    // One decoded "row,col" line
    typedef struct packed {
        logic [`JTAG_GRID_BITS-1:0] row;
        logic [`JTAG_GRID_BITS-1:0] col;
    } tile_t;

    // Captured DR word; done sits in bit 0 so it leaves on tdo first
    typedef struct packed {
        logic [`JTAG_RESULT_WIDTH-1:0] sum;
        logic                          done;
    } result_t;

    // Line parser states
    typedef enum logic [1:0] {
        LINE_ROW = 2'd0,
        LINE_COL = 2'd1,
        LINE_EOF = 2'd2
    } line_state_e;

endpackage

// ==== logic/tap_decoder.sv ====
`timescale 1ns/1ps
`include "jtag_user_config.svh"

module tap_decoder (
    input  logic                        tck,
    input  logic                        tdi,
    input  logic                        test_logic_reset,
    input  logic                        ir_is_user,
    input  logic                        shift_dr,
    input  logic                        update_dr,
    output logic                        byte_valid,
    output logic [`JTAG_BYTE_WIDTH-1:0] byte_data
);

    logic [`JTAG_BYTE_WIDTH-1:0] shift_reg;

    // LSB arrives first, so new bits enter at the top
    always_ff @(posedge tck) begin
        if (shift_dr && ir_is_user) begin
            shift_reg <= {tdi, shift_reg[`JTAG_BYTE_WIDTH-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= update_dr && ir_is_user;
        end
    end

    // Byte is held until the next user update
    always_ff @(posedge tck) begin
        if (update_dr && ir_is_user) begin
            byte_data <= shift_reg;
        end
    end

    // Update-DR is a single TAP state, never two in a row
    a_single_byte_strobe: assert property (
        @(posedge tck) disable iff (test_logic_reset)
        byte_valid |=> !byte_valid
    );

endmodule

// ==== logic/line_decoder.sv ====
`timescale 1ns/1ps
`include "jtag_user_config.svh"

module line_decoder (
    input  logic                        tck,
    input  logic                        test_logic_reset,
    input  logic                        byte_valid,
    input  logic [`JTAG_BYTE_WIDTH-1:0] byte_data,
    output logic                        tile_valid,
    output jtag_user_pkg::tile_t        tile,
    output logic                        end_of_file
);

    localparam logic [`JTAG_BYTE_WIDTH-1:0] char_nul   = 8'h00;
    localparam logic [`JTAG_BYTE_WIDTH-1:0] char_lf    = 8'h0A;
    localparam logic [`JTAG_BYTE_WIDTH-1:0] char_comma = 8'h2C;
    localparam logic [`JTAG_BYTE_WIDTH-1:0] char_zero  = 8'h30;
    localparam logic [`JTAG_BYTE_WIDTH-1:0] char_nine  = 8'h39;

    jtag_user_pkg::line_state_e state;

    logic [`JTAG_GRID_BITS-1:0] row;
    logic [`JTAG_GRID_BITS-1:0] col;
    logic                       is_digit;
    logic [3:0]                 digit;
    logic                       emit_tile;

    // value * 10 + digit wraps at the grid width
    function automatic logic [`JTAG_GRID_BITS-1:0] add_digit(
        input logic [`JTAG_GRID_BITS-1:0] value,
        input logic [3:0]                 new_digit
    );
        logic [`JTAG_GRID_BITS-1:0] times_ten;
        times_ten = (value << 3) + (value << 1);
        return times_ten + {{(`JTAG_GRID_BITS-4){1'b0}}, new_digit};
    endfunction

    // ASCII digits keep their value in the low nibble
    assign is_digit  = (byte_data >= char_zero) && (byte_data <= char_nine);
    assign digit     = byte_data[3:0];
    assign emit_tile = byte_valid && (state == jtag_user_pkg::LINE_COL)
                       && (byte_data == char_lf);

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            state      <= jtag_user_pkg::LINE_ROW;
            tile_valid <= 1'b0;
            row        <= '0;
            col        <= '0;
        end else begin
            tile_valid <= emit_tile;
            if (byte_valid) begin
                case (state)
                    jtag_user_pkg::LINE_ROW: begin
                        if (is_digit) begin
                            row <= add_digit(row, digit);
                        end else if (byte_data == char_comma) begin
                            state <= jtag_user_pkg::LINE_COL;
                        end else if (byte_data == char_nul) begin
                            state <= jtag_user_pkg::LINE_EOF;
                        end
                    end
                    jtag_user_pkg::LINE_COL: begin
                        if (is_digit) begin
                            col <= add_digit(col, digit);
                        end else if (byte_data == char_lf) begin
                            row   <= '0;
                            col   <= '0;
                            state <= jtag_user_pkg::LINE_ROW;
                        end else if (byte_data == char_nul) begin
                            state <= jtag_user_pkg::LINE_EOF;
                        end
                    end
                    // Sticky until reset
                    jtag_user_pkg::LINE_EOF: begin
                        state <= jtag_user_pkg::LINE_EOF;
                    end
                    default: begin
                        state <= jtag_user_pkg::LINE_ROW;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge tck) begin
        if (emit_tile) begin
            tile <= '{row: row, col: col};
        end
    end

    assign end_of_file = (state == jtag_user_pkg::LINE_EOF);

    // A single byte is either a line feed or a NUL, not both
    a_tile_or_eof: assert property (
        @(posedge tck) disable iff (test_logic_reset)
        !(tile_valid && $rose(end_of_file))
    );

endmodule

// ==== logic/tile_accumulator.sv ====
`timescale 1ns/1ps
`include "jtag_user_config.svh"

module tile_accumulator (
    input  logic                   tck,
    input  logic                   test_logic_reset,
    input  logic                   tile_valid,
    input  jtag_user_pkg::tile_t   tile,
    input  logic                   end_of_file,
    output jtag_user_pkg::result_t result
);

    // At most 2 * 18 set bits per tile
    logic [5:0] tile_ones;

    always_comb begin
        tile_ones = 6'($countones(tile.row)) + 6'($countones(tile.col));
    end

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            result.sum  <= '0;
            result.done <= 1'b0;
        end else begin
            result.done <= end_of_file;
            if (tile_valid) begin
                // wraps silently at the result width
                result.sum <= result.sum + {{(`JTAG_RESULT_WIDTH-6){1'b0}}, tile_ones};
            end
        end
    end

    // Parser stops emitting once the NUL has been seen
    a_no_tile_after_done: assert property (
        @(posedge tck) disable iff (test_logic_reset)
        result.done |-> !tile_valid
    );

endmodule

// ==== logic/tap_encoder.sv ====
`timescale 1ns/1ps
`include "jtag_user_config.svh"

module tap_encoder (
    input  logic                   tck,
    input  logic                   test_logic_reset,
    input  logic                   ir_is_user,
    input  logic                   capture_dr,
    input  logic                   shift_dr,
    input  jtag_user_pkg::result_t result,
    output logic                   tdo
);

    // Sum plus the done flag
    logic [`JTAG_RESULT_WIDTH:0] shift_reg;
    logic                        user_capture;
    logic                        user_shift;

    assign user_capture = capture_dr && ir_is_user;
    assign user_shift   = shift_dr && ir_is_user;

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            shift_reg <= '0;
        end else if (user_capture) begin
            shift_reg <= result;
        end else if (user_shift) begin
            shift_reg <= {1'b0, shift_reg[`JTAG_RESULT_WIDTH:1]};
        end
    end

    // Done first, then sum LSB upward
    assign tdo = shift_reg[0];

    // Capture-DR and Shift-DR are distinct TAP states
    a_capture_not_shift: assert property (
        @(posedge tck) disable iff (test_logic_reset)
        !(capture_dr && shift_dr)
    );

endmodule

// ==== logic/user_logic.sv ====
`timescale 1ns/1ps
`include "jtag_user_config.svh"

module user_logic (
    // Raw JTAG pins
    input  logic tck,
    input  logic tdi,
    output logic tdo,
    // TAP controller state levels
    input  logic test_logic_reset,
    input  logic run_test_idle,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr
);

    logic                        byte_valid;
    logic [`JTAG_BYTE_WIDTH-1:0] byte_data;

    logic                        tile_valid;
    jtag_user_pkg::tile_t        tile;
    logic                        end_of_file;

    jtag_user_pkg::result_t      result;

    // Inbound bytes, one per DR scan
    tap_decoder tap_decoder_i (
        .tck              (tck),
        .tdi              (tdi),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .byte_valid       (byte_valid),
        .byte_data        (byte_data)
    );

    line_decoder line_decoder_i (
        .tck              (tck),
        .test_logic_reset (test_logic_reset),
        .byte_valid       (byte_valid),
        .byte_data        (byte_data),
        .tile_valid       (tile_valid),
        .tile             (tile),
        .end_of_file      (end_of_file)
    );

    tile_accumulator tile_accumulator_i (
        .tck              (tck),
        .test_logic_reset (test_logic_reset),
        .tile_valid       (tile_valid),
        .tile             (tile),
        .end_of_file      (end_of_file),
        .result           (result)
    );

    // Outbound result word on tdo
    tap_encoder tap_encoder_i (
        .tck              (tck),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .result           (result),
        .tdo              (tdo)
    );

    // Idle state is not needed by this DR
    wire unused_ok = 1'b0 && &{1'b0, run_test_idle, 1'b0};

endmodule

// ==== verification/user_logic_checker.sv ====
`timescale 1ns/1ps
`include "jtag_user_config.svh"

module user_logic_checker (
    input  logic                          tck,
    input  logic                          tdo,
    input  logic                          ir_is_user,
    input  logic                          shift_dr,
    input  logic                          read_active,
    input  logic                          exp_done,
    input  logic [`JTAG_RESULT_WIDTH-1:0] exp_sum,
    input  logic [127:0]                  test_name,
    input  jtag_user_pkg::line_state_e    parser_state,
    output int                            checks_done,
    output int                            error_count
);

    localparam int word_bits = `JTAG_RESULT_WIDTH + 1;

    logic [word_bits-1:0] word;
    int                   bit_count;

    initial begin
        checks_done = 0;
        error_count = 0;
        bit_count   = 0;
    end

    task automatic compare_word(input logic [word_bits-1:0] captured);
        jtag_user_pkg::line_state_e exp_state;
        int                         errors_before;
        errors_before = error_count;
        // Every line in the table ends in LF, so the parser rests in LINE_ROW
        exp_state = exp_done ? jtag_user_pkg::LINE_EOF : jtag_user_pkg::LINE_ROW;
        if (captured[0] !== exp_done) begin
            $display("Mismatch at %0d ns: done expected %0d got %0d",
                     $time, exp_done, captured[0]);
            error_count++;
        end
        if (captured[word_bits-1:1] !== exp_sum) begin
            $display("Mismatch at %0d ns: sum expected %0d got %0d",
                     $time, exp_sum, captured[word_bits-1:1]);
            error_count++;
        end
        if (parser_state !== exp_state) begin
            $display("Mismatch at %0d ns: parser_state expected %0d got %0d",
                     $time, exp_state, parser_state);
            error_count++;
        end
        $display("Test %0s: done=%0d sum=%0d %s", test_name, captured[0],
                 captured[word_bits-1:1], (error_count == errors_before) ? "ok" : "failed");
        checks_done++;
    endtask

    // tdo is settled half a cycle after the shift edge
    always @(negedge tck) begin : sample_tdo
        logic [word_bits-1:0] next_word;
        if (!read_active) begin
            bit_count = 0;
        end else if (shift_dr && ir_is_user) begin
            next_word = {tdo, word[word_bits-1:1]};
            word      = next_word;
            bit_count++;
            if (bit_count == word_bits) begin
                compare_word(next_word);
            end
        end
    end

endmodule

// ==== verification/user_logic_tb.sv ====
`timescale 1ns/1ps
`include "jtag_user_config.svh"

module user_logic_tb;

    localparam int max_tests = 8;

    logic tck;
    logic tdi;
    logic tdo;
    logic test_logic_reset;
    logic run_test_idle;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;

    logic                          read_active;
    logic                          exp_done;
    logic [`JTAG_RESULT_WIDTH-1:0] exp_sum;
    logic [127:0]                  test_name;
    int                            checks_done;
    int                            error_count;

    // Stimulus table
    logic [127:0]                  name_tab [max_tests];
    string                         text_tab [max_tests];
    bit                            reset_tab [max_tests];
    bit                            nul_tab [max_tests];
    bit                            user_low_tab [max_tests];
    bit                            done_tab [max_tests];
    logic [`JTAG_RESULT_WIDTH-1:0] sum_tab [max_tests];
    int                            num_tests;

    // Reference model while the table is built
    string                         build_text;
    logic [`JTAG_RESULT_WIDTH-1:0] build_ones;
    logic [`JTAG_RESULT_WIDTH-1:0] model_sum;
    bit                            model_done;
    logic [31:0]                   lfsr;
    logic [`JTAG_GRID_BITS-1:0]    rand_row;
    logic [`JTAG_GRID_BITS-1:0]    rand_col;
    bit                            timed_out;

    user_logic i_dut (
        .tck              (tck),
        .tdi              (tdi),
        .tdo              (tdo),
        .test_logic_reset (test_logic_reset),
        .run_test_idle    (run_test_idle),
        .ir_is_user       (ir_is_user),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr)
    );

    user_logic_checker i_checker (
        .tck          (tck),
        .tdo          (tdo),
        .ir_is_user   (ir_is_user),
        .shift_dr     (shift_dr),
        .read_active  (read_active),
        .exp_done     (exp_done),
        .exp_sum      (exp_sum),
        .test_name    (test_name),
        .parser_state (i_dut.line_decoder_i.state),
        .checks_done  (checks_done),
        .error_count  (error_count)
    );

    initial begin
        tck = 1'b0;
        forever #10 tck = ~tck;
    end

    function automatic logic [`JTAG_RESULT_WIDTH-1:0] count_ones(
        input logic [`JTAG_GRID_BITS-1:0] value
    );
        logic [`JTAG_RESULT_WIDTH-1:0] ones;
        ones = '0;
        for (int b = 0; b < `JTAG_GRID_BITS; b++) begin
            ones += value[b];
        end
        return ones;
    endfunction

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic random_coord(output logic [`JTAG_GRID_BITS-1:0] value);
        for (int b = 0; b < `JTAG_GRID_BITS; b++) begin
            lfsr     = lfsr_step(lfsr);
            value[b] = lfsr[0];
        end
    endtask

    task automatic add_line(input logic [`JTAG_GRID_BITS-1:0] row,
                            input logic [`JTAG_GRID_BITS-1:0] col, input bit with_cr);
        build_text = {build_text, $sformatf("%0d,%0d", row, col)};
        if (with_cr) begin
            build_text = {build_text, "\r"};
        end
        build_text = {build_text, "\n"};
        build_ones += count_ones(row) + count_ones(col);
    endtask

    task automatic add_test(input logic [127:0] name, input bit reset_first,
                            input bit add_nul, input bit user_low);
        if (reset_first) begin
            model_sum  = '0;
            model_done = 1'b0;
        end
        // Parser ignores everything once EOF is latched
        if (!user_low && !model_done) begin
            model_sum += build_ones;
        end
        if (!user_low && add_nul) begin
            model_done = 1'b1;
        end
        name_tab[num_tests]     = name;
        text_tab[num_tests]     = build_text;
        reset_tab[num_tests]    = reset_first;
        nul_tab[num_tests]      = add_nul;
        user_low_tab[num_tests] = user_low;
        done_tab[num_tests]     = model_done;
        sum_tab[num_tests]      = model_sum;
        num_tests++;
        build_text = "";
        build_ones = '0;
    endtask

    task next_cycle();
        @(posedge tck);
        #2;
    endtask

    task apply_reset();
        test_logic_reset = 1'b1;
        repeat (8) next_cycle();
        test_logic_reset = 1'b0;
    endtask

    // One DR scan with LSB first, then Update-DR
    task automatic send_byte(input logic [7:0] value, input logic user);
        ir_is_user = user;
        for (int b = 0; b < 8; b++) begin
            tdi      = value[b];
            shift_dr = 1'b1;
            next_cycle();
        end
        shift_dr  = 1'b0;
        update_dr = 1'b1;
        next_cycle();
        update_dr = 1'b0;
    endtask

    task automatic read_result(input int t);
        ir_is_user  = 1'b1;
        test_name   = name_tab[t];
        exp_done    = done_tab[t];
        exp_sum     = sum_tab[t];
        read_active = 1'b1;
        capture_dr  = 1'b1;
        next_cycle();
        capture_dr = 1'b0;
        shift_dr   = 1'b1;
        repeat (`JTAG_RESULT_WIDTH + 1) next_cycle();
        shift_dr    = 1'b0;
        read_active = 1'b0;
        next_cycle();
    endtask

    task automatic wait_for_check(input int target, output bit expired);
        int waited;
        waited = 0;
        while (checks_done < target && waited < 40) begin
            next_cycle();
            waited++;
        end
        expired = (checks_done < target);
    endtask

    initial begin
        tdi              = 1'b0;
        test_logic_reset = 1'b1;
        run_test_idle    = 1'b0;
        ir_is_user       = 1'b1;
        capture_dr       = 1'b0;
        shift_dr         = 1'b0;
        update_dr        = 1'b0;
        read_active      = 1'b0;
        exp_done         = 1'b0;
        exp_sum          = '0;
        test_name        = '0;
        num_tests        = 0;
        build_text       = "";
        build_ones       = '0;
        model_sum        = '0;
        model_done       = 1'b0;
        lfsr             = 32'he25d_9896;
        timed_out        = 1'b0;

        add_test("after_reset", 1'b1, 1'b0, 1'b0);
        add_line(3, 5, 1'b0);
        add_line(12, 7, 1'b0);
        add_test("partial", 1'b0, 1'b0, 1'b0);
        add_line(8, 8, 1'b0);
        add_test("user_low", 1'b0, 1'b1, 1'b1);
        add_line(1023, 4096, 1'b1);
        add_line(131071, 65535, 1'b1);
        add_line(262143, 262143, 1'b0);
        add_line(0, 0, 1'b0);
        add_line(42, 100000, 1'b1);
        add_test("full_file", 1'b1, 1'b1, 1'b0);
        add_line(9, 9, 1'b0);
        add_test("after_nul", 1'b0, 1'b0, 1'b0);
        for (int n = 0; n < 16; n++) begin
            random_coord(rand_row);
            random_coord(rand_col);
            add_line(rand_row, rand_col, 1'b0);
        end
        add_test("random", 1'b1, 1'b1, 1'b0);
        add_test("reset_again", 1'b1, 1'b0, 1'b0);

        for (int t = 0; t < num_tests; t++) begin
            if (reset_tab[t]) begin
                apply_reset();
            end
            for (int k = 0; k < text_tab[t].len(); k++) begin
                send_byte(text_tab[t][k], !user_low_tab[t]);
            end
            if (nul_tab[t]) begin
                send_byte(8'h00, !user_low_tab[t]);
            end
            ir_is_user = 1'b1;
            repeat (6) next_cycle();
            read_result(t);
            wait_for_check(t + 1, timed_out);
            if (timed_out) begin
                $display("Timeout: no result was checked for test %0s", name_tab[t]);
                break;
            end
        end

        $display("Summary: %0d of %0d tests checked, %0d errors",
                 checks_done, num_tests, error_count);
        if (!timed_out && error_count == 0 && checks_done == num_tests) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/jtag_user_pkg.sv
logic/tap_decoder.sv
logic/line_decoder.sv
logic/tile_accumulator.sv
logic/tap_encoder.sv
logic/user_logic.sv
verification/user_logic_checker.sv
verification/user_logic_tb.sv
